/* menuPkg.sv */
package menuPkg;

	//////////////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////////////

	// LCD and RAM character address
	localparam int addrWidth = 5;
	// Character code, column over row
	localparam int charWidth = 8;
	// Column or row index
	localparam int nibbleWidth = 4;
	// Menu screen selector
	localparam int itemWidth = 5;
	// RAM bank select
	localparam int selWidth = 2;

	typedef logic [addrWidth-1:0] lcdAddrT;
	typedef logic [charWidth-1:0] charT;
	typedef logic [nibbleWidth-1:0] nibbleT;
	typedef logic [itemWidth-1:0] menuItemT;
	typedef logic [selWidth-1:0] ramSelT;

	//////////////////////////////////////////////////////////////////////////////
	// Menu bank screens
	//////////////////////////////////////////////////////////////////////////////

	// Titles, shown on line 1
	localparam menuItemT mainTitle = 5'd0;
	localparam menuItemT titleAreYouSure = 5'd8;
	// Main menu ring, shown on line 2
	localparam menuItemT optDisplayLocal = 5'd3;
	localparam menuItemT optModifyLocal = 5'd4;
	localparam menuItemT optClearLocal = 5'd5;
	// Clear confirmation pair
	localparam menuItemT optYes = 5'd9;
	localparam menuItemT optNo = 5'd10;

	// Bank codes; bank 1 belonged to the remote side
	localparam ramSelT bankMenu = 2'd0;
	localparam ramSelT bankLocal = 2'd2;

	// LCD geometry, two lines of 16
	localparam int lineLen = 16;
	localparam int screenLen = 32;

	// Home character is letter A
	localparam nibbleT firstCharCol = 4'd4;
	localparam nibbleT firstCharRow = 4'd1;

	// Column wrap points
	// Columns 0-1 and 8-9 hold no printable glyphs
	localparam nibbleT colWrapLow = 4'd2;
	localparam nibbleT colWrapHigh = 4'd15;
	localparam nibbleT gapLow = 4'd7;
	localparam nibbleT gapHigh = 4'd10;

	//////////////////////////////////////////////////////////////////////////////
	// Sequencer states
	//////////////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		refreshTitle,
		refreshOption,
		startCopy,
		waitCopy,
		waitSelection,
		showLocal,
		waitExit,
		editScreen,
		editPos,
		editChar,
		commitChar,
		clearConfirm,
		clearRam
	} seqStateT;

endpackage

/* lcdBusIf.sv */
`timescale 1ns/100ps

interface lcdBusIf;
	import menuPkg::*;

	// Copy request pulse
	logic start;
	// LCD range, inclusive on both ends
	lcdAddrT firstAddr;
	lcdAddrT lastAddr;
	// Level, take charData instead of RAM output
	logic useChar;
	charT charData;
	// Pulse after the last write
	logic done;

	// Sequencer side
	modport requester (
		output start, firstAddr, lastAddr, useChar, charData,
		input done
	);

	// LCD writer side
	modport writer (
		input start, firstAddr, lastAddr, useChar, charData,
		output done
	);

endinterface

/* lcdWriter.sv */
`timescale 1ns/100ps

module lcdWriter (
	input logic clk,
	input logic rstN,
	lcdBusIf.writer bus,
	input menuPkg::charT ramDout,
	output menuPkg::lcdAddrT ramAddr,
	output menuPkg::lcdAddrT lcdAddr,
	output menuPkg::charT lcdData,
	output logic lcdWrite
);
	import menuPkg::*;

	// Copy in progress
	logic busy;
	// Low for setup cycle, high for write cycle
	logic writePhase;
	logic doneQ;

	//////////////////////////////////////////////////////////////////////////////
	// Copy walk
	//////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			writePhase <= 1'b0;
			doneQ <= 1'b0;
			ramAddr <= '0;
			lcdAddr <= '0;
		end
		else
		begin
			doneQ <= 1'b0;
			if (!busy)
			begin
				// New request, start from RAM address 0
				if (bus.start)
				begin
					busy <= 1'b1;
					writePhase <= 1'b0;
					ramAddr <= '0;
					lcdAddr <= bus.firstAddr;
				end
			end
			else if (!writePhase)
			begin
				// RAM data settles during setup
				writePhase <= 1'b1;
			end
			else
			begin
				writePhase <= 1'b0;
				// Last character just went out
				if (lcdAddr == bus.lastAddr)
				begin
					busy <= 1'b0;
					doneQ <= 1'b1;
				end
				else
				begin
					ramAddr <= ramAddr + 1'b1;
					lcdAddr <= lcdAddr + 1'b1;
				end
			end
		end
	end

	// Strobe on second half of each character
	assign lcdWrite = busy && writePhase;
	assign bus.done = doneQ;

	// Single character or RAM window
	assign lcdData = bus.useChar ? bus.charData : ramDout;

endmodule

/* charPicker.sv */
`timescale 1ns/100ps

module charPicker (
	input logic clk,
	input logic rstN,
	input logic home,
	input logic posActive,
	input logic charActive,
	input logic rotaryEvent,
	input logic rotaryLeft,
	input logic colLeftBtn,
	input logic colRightBtn,
	input logic shown,
	output menuPkg::lcdAddrT charPos,
	output menuPkg::charT currentChar,
	output logic charDirty,
	output logic cursorLeft,
	output logic cursorRight
);
	import menuPkg::*;

	// Character table indices
	nibbleT charCol;
	nibbleT charRow;
	// Last character put on the LCD
	charT shownChar;

	assign currentChar = {charCol, charRow};
	// Redraw needed
	assign charDirty = shownChar != currentChar;

	always_ff @(posedge clk)
	begin
		if (!rstN || home)
		begin
			// Back to position 0 and letter A
			charPos <= '0;
			charCol <= firstCharCol;
			charRow <= firstCharRow;
			shownChar <= {firstCharCol, firstCharRow};
			cursorLeft <= 1'b0;
			cursorRight <= 1'b0;
		end
		else
		begin
			cursorLeft <= 1'b0;
			cursorRight <= 1'b0;

			// Position select, cursor follows the rotation
			if (posActive && rotaryEvent)
			begin
				if (rotaryLeft)
				begin
					charPos <= charPos + 1'b1;
					cursorRight <= 1'b1;
				end
				else
				begin
					charPos <= charPos - 1'b1;
					cursorLeft <= 1'b1;
				end
			end

			// Character select
			if (charActive)
			begin
				// Rotation walks the row
				if (rotaryEvent)
				begin
					if (rotaryLeft)
						charRow <= charRow + 1'b1;
					else
						charRow <= charRow - 1'b1;
				end
				else if (colLeftBtn)
				begin
					// Skip the empty columns going down
					case (charCol)
						colWrapLow: charCol <= colWrapHigh;
						gapHigh: charCol <= gapLow;
						default: charCol <= charCol - 1'b1;
					endcase
				end
				else if (colRightBtn)
				begin
					// And going up
					case (charCol)
						gapLow: charCol <= gapHigh;
						colWrapHigh: charCol <= colWrapLow;
						default: charCol <= charCol + 1'b1;
					endcase
				end
			end

			// Sequencer has drawn it
			if (shown)
				shownChar <= currentChar;
		end
	end

endmodule

/* menuSequencer.sv */
`timescale 1ns/100ps

module menuSequencer (
	input logic clk,
	input logic rstN,
	input logic menuBtn,
	input logic rotaryBtn,
	input logic rotaryEvent,
	input logic rotaryLeft,
	input menuPkg::lcdAddrT charPos,
	input menuPkg::charT currentChar,
	input logic charDirty,
	lcdBusIf.requester bus,
	output logic home,
	output logic posActive,
	output logic charActive,
	output logic shown,
	output logic enableCursor,
	output menuPkg::menuItemT menuSelect,
	output menuPkg::ramSelT ramSel,
	output menuPkg::lcdAddrT ramWriteAddr,
	output menuPkg::charT ramDin,
	output logic ramWrite,
	output logic ramClear
);
	import menuPkg::*;

	seqStateT state;
	// Where to go once the copy is done
	seqStateT afterCopy;
	// Option shown on line 2
	menuItemT displayOption;
	// Writer still walking, possibly an aborted copy
	logic copyBusy;

	//////////////////////////////////////////////////////////////////////////////
	// Strobes and levels
	//////////////////////////////////////////////////////////////////////////////

	assign bus.start = state == startCopy;
	assign home = menuBtn;
	assign posActive = state == editPos;
	assign charActive = state == editChar;
	assign enableCursor = state == editPos;
	// Latches the drawn character in the picker
	assign shown = (state == editChar) && !rotaryBtn && charDirty;
	assign ramWrite = state == commitChar;
	assign ramClear = state == clearRam;

	always_ff @(posedge clk)
	begin
		if (!rstN)
			copyBusy <= 1'b0;
		else if (bus.start)
			copyBusy <= 1'b1;
		else if (bus.done)
			copyBusy <= 1'b0;
	end

	//////////////////////////////////////////////////////////////////////////////
	// Menu FSM
	//////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rstN || menuBtn)
		begin
			state <= refreshTitle;
			displayOption <= optDisplayLocal;
			// Copy operands stay put while an aborted copy drains
			if (!rstN)
			begin
				bus.useChar <= 1'b0;
				afterCopy <= refreshOption;
			end
		end
		else
		begin
			case (state)
				refreshTitle:
				begin
					if (!copyBusy)
					begin
						// Title on line 1
						ramSel <= bankMenu;
						bus.useChar <= 1'b0;
						bus.firstAddr <= '0;
						bus.lastAddr <= lcdAddrT'(lineLen - 1);
						if (displayOption == optYes || displayOption == optNo)
							menuSelect <= titleAreYouSure;
						else
							menuSelect <= mainTitle;
						afterCopy <= refreshOption;
						state <= startCopy;
					end
				end
				refreshOption:
				begin
					// Option on line 2
					menuSelect <= displayOption;
					bus.firstAddr <= lcdAddrT'(lineLen);
					bus.lastAddr <= lcdAddrT'(screenLen - 1);
					afterCopy <= waitSelection;
					state <= startCopy;
				end
				startCopy:
					state <= waitCopy;
				waitCopy:
				begin
					if (bus.done)
						state <= afterCopy;
				end
				waitSelection:
				begin
					if (rotaryBtn)
					begin
						case (displayOption)
							optDisplayLocal: state <= showLocal;
							optModifyLocal: state <= editScreen;
							optClearLocal: state <= clearConfirm;
							optYes:
							begin
								ramSel <= bankLocal;
								state <= clearRam;
							end
							default:
							begin
								// No, back without clearing
								displayOption <= optDisplayLocal;
								state <= refreshTitle;
							end
						endcase
					end
					else if (rotaryEvent)
					begin
						// Ring of three, or the Yes/No toggle
						case (displayOption)
							optDisplayLocal:
								displayOption <= rotaryLeft ? optModifyLocal : optClearLocal;
							optModifyLocal:
								displayOption <= rotaryLeft ? optClearLocal : optDisplayLocal;
							optClearLocal:
								displayOption <= rotaryLeft ? optDisplayLocal : optModifyLocal;
							optYes: displayOption <= optNo;
							optNo: displayOption <= optYes;
							default: displayOption <= optDisplayLocal;
						endcase
						state <= refreshTitle;
					end
				end
				showLocal, editScreen:
				begin
					// Whole local bank onto both lines
					ramSel <= bankLocal;
					bus.useChar <= 1'b0;
					bus.firstAddr <= '0;
					bus.lastAddr <= lcdAddrT'(screenLen - 1);
					afterCopy <= (state == showLocal) ? waitExit : editPos;
					state <= startCopy;
				end
				waitExit:
				begin
					if (rotaryBtn)
						state <= refreshTitle;
				end
				editPos:
				begin
					if (rotaryBtn)
						state <= editChar;
				end
				editChar:
				begin
					if (rotaryBtn)
					begin
						// Commit, address comes from here
						ramWriteAddr <= charPos;
						ramDin <= currentChar;
						bus.useChar <= 1'b1;
						state <= commitChar;
					end
					else if (charDirty)
					begin
						// Redraw one character at the cursor
						bus.useChar <= 1'b1;
						bus.charData <= currentChar;
						bus.firstAddr <= charPos;
						bus.lastAddr <= charPos;
						afterCopy <= editChar;
						state <= startCopy;
					end
				end
				commitChar:
					state <= editPos;
				clearConfirm:
				begin
					// Yes comes up first
					displayOption <= optYes;
					state <= refreshTitle;
				end
				clearRam:
				begin
					displayOption <= optDisplayLocal;
					state <= refreshTitle;
				end
				default:
					state <= refreshTitle;
			endcase
		end
	end

endmodule

/* lcdMenuTop.sv */
`timescale 1ns/100ps

module lcdMenuTop (
	input logic clk,
	input logic rstN,
	input logic rotaryEvent,
	input logic rotaryLeft,
	input logic rotaryBtn,
	input logic colLeftBtn,
	input logic colRightBtn,
	input logic menuBtn,
	input menuPkg::charT ramDout,
	output menuPkg::lcdAddrT lcdAddr,
	output menuPkg::charT lcdData,
	output logic lcdWrite,
	output logic enableCursor,
	output logic cursorLeft,
	output logic cursorRight,
	output menuPkg::menuItemT menuSelect,
	output menuPkg::ramSelT ramSel,
	output menuPkg::lcdAddrT ramAddr,
	output menuPkg::charT ramDin,
	output logic ramWrite,
	output logic ramClear
);
	import menuPkg::*;

	// Sequencer to picker
	logic home;
	logic posActive;
	logic charActive;
	logic shown;
	// Picker to sequencer
	lcdAddrT charPos;
	charT currentChar;
	logic charDirty;
	// Two RAM address sources
	lcdAddrT writerRamAddr;
	lcdAddrT ramWriteAddr;

	lcdBusIf bus0 ();

	lcdWriter writer0 (
		.clk(clk),
		.rstN(rstN),
		.bus(bus0.writer),
		.ramDout(ramDout),
		.ramAddr(writerRamAddr),
		.lcdAddr(lcdAddr),
		.lcdData(lcdData),
		.lcdWrite(lcdWrite)
	);

	charPicker picker0 (
		.clk(clk),
		.rstN(rstN),
		.home(home),
		.posActive(posActive),
		.charActive(charActive),
		.rotaryEvent(rotaryEvent),
		.rotaryLeft(rotaryLeft),
		.colLeftBtn(colLeftBtn),
		.colRightBtn(colRightBtn),
		.shown(shown),
		.charPos(charPos),
		.currentChar(currentChar),
		.charDirty(charDirty),
		.cursorLeft(cursorLeft),
		.cursorRight(cursorRight)
	);

	menuSequencer seq0 (
		.clk(clk),
		.rstN(rstN),
		.menuBtn(menuBtn),
		.rotaryBtn(rotaryBtn),
		.rotaryEvent(rotaryEvent),
		.rotaryLeft(rotaryLeft),
		.charPos(charPos),
		.currentChar(currentChar),
		.charDirty(charDirty),
		.bus(bus0.requester),
		.home(home),
		.posActive(posActive),
		.charActive(charActive),
		.shown(shown),
		.enableCursor(enableCursor),
		.menuSelect(menuSelect),
		.ramSel(ramSel),
		.ramWriteAddr(ramWriteAddr),
		.ramDin(ramDin),
		.ramWrite(ramWrite),
		.ramClear(ramClear)
	);

	// Writer never reads RAM while useChar is up
	assign ramAddr = bus0.useChar ? ramWriteAddr : writerRamAddr;

endmodule

/* tbLcdMenu.sv */
`timescale 1ns/100ps

module tbLcdMenu;
	import menuPkg::*;

	logic clk = 1'b0;
	logic rstN;
	logic rotaryEvent;
	logic rotaryLeft;
	logic rotaryBtn;
	logic colLeftBtn;
	logic colRightBtn;
	logic menuBtn;
	charT ramDout;
	lcdAddrT lcdAddr;
	charT lcdData;
	logic lcdWrite;
	logic enableCursor;
	logic cursorLeft;
	logic cursorRight;
	menuItemT menuSelect;
	ramSelT ramSel;
	lcdAddrT ramAddr;
	charT ramDin;
	logic ramWrite;
	logic ramClear;

	// Local bank model, its seed and the expected contents
	charT localRam [0:31];
	charT seedRam [0:31];
	charT expRam [0:31];
	// Every LCD write lands here
	charT shadowLcd [0:31];
	// Four bytes per step: op, check kind, two arguments
	logic [7:0] patMem [0:255];

	// Strobe counters, written only by the monitor
	int leftCount = 0;
	int rightCount = 0;
	int lcdWriteCount = 0;
	int ramWriteCount = 0;
	int clearCount = 0;
	int quietCount = 0;
	lcdAddrT lastLcdAddr;
	lcdAddrT lastRamAddr;
	charT lastRamDin;
	// Counter values at the start of the last input
	int leftBase;
	int rightBase;
	int lcdWriteBase;
	int ramWriteBase;
	int clearBase;

	int checkCount = 0;
	int errorCount = 0;

	// 4 ns period
	always #2 clk = ~clk;

	lcdMenuTop dut0 (
		.clk(clk),
		.rstN(rstN),
		.rotaryEvent(rotaryEvent),
		.rotaryLeft(rotaryLeft),
		.rotaryBtn(rotaryBtn),
		.colLeftBtn(colLeftBtn),
		.colRightBtn(colRightBtn),
		.menuBtn(menuBtn),
		.ramDout(ramDout),
		.lcdAddr(lcdAddr),
		.lcdData(lcdData),
		.lcdWrite(lcdWrite),
		.enableCursor(enableCursor),
		.cursorLeft(cursorLeft),
		.cursorRight(cursorRight),
		.menuSelect(menuSelect),
		.ramSel(ramSel),
		.ramAddr(ramAddr),
		.ramDin(ramDin),
		.ramWrite(ramWrite),
		.ramClear(ramClear)
	);

	////////////////////////////////////////////////////////////////////////////
	// Character RAM model
	////////////////////////////////////////////////////////////////////////////

	// Menu bank text, screen code over character index
	function automatic charT menuText(input menuItemT item, input lcdAddrT addr);
		return {item[3:0], addr[3:0]};
	endfunction

	assign ramDout = (ramSel == bankLocal) ? localRam[ramAddr] : menuText(menuSelect, ramAddr);

	// RAM writes, shadow LCD and strobe counts
	always @(posedge clk)
	begin : monitor
		int i;
		if (!rstN)
		begin
			for (i = 0; i < 32; i++)
				localRam[i] <= seedRam[i];
		end
		else if (ramClear && ramSel == bankLocal)
		begin
			for (i = 0; i < 32; i++)
				localRam[i] <= '0;
		end
		else if (ramWrite && ramSel == bankLocal)
			localRam[ramAddr] <= ramDin;
		if (lcdWrite)
		begin
			shadowLcd[lcdAddr] <= lcdData;
			lastLcdAddr <= lcdAddr;
			lcdWriteCount <= lcdWriteCount + 1;
		end
		if (ramWrite)
		begin
			lastRamAddr <= ramAddr;
			lastRamDin <= ramDin;
			ramWriteCount <= ramWriteCount + 1;
		end
		if (ramClear)
			clearCount <= clearCount + 1;
		if (cursorLeft)
			leftCount <= leftCount + 1;
		if (cursorRight)
			rightCount <= rightCount + 1;
		// Quiet time restarts on any input or LCD write
		if (!rstN || lcdWrite || rotaryEvent || rotaryBtn || colLeftBtn || colRightBtn || menuBtn)
			quietCount <= 0;
		else
			quietCount <= quietCount + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic checkChar(input string name, input charT actual, input charT expected);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("[FAIL] %0t %s: got %h expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic checkItem(input string name, input menuItemT actual, input menuItemT expected);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("[FAIL] %0t %s: got %0d expected %0d", $time, name, actual, expected);
		end
	endtask

	task automatic checkAddr(input string name, input lcdAddrT actual, input lcdAddrT expected);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("[FAIL] %0t %s: got %0d expected %0d", $time, name, actual, expected);
		end
	endtask

	task automatic checkPulse(input string name, input logic actual, input logic expected);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("[FAIL] %0t %s: got %b expected %b", $time, name, actual, expected);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	// One-cycle strobe for one user input
	task automatic applyOp(input logic [7:0] op);
		leftBase = leftCount;
		rightBase = rightCount;
		lcdWriteBase = lcdWriteCount;
		ramWriteBase = ramWriteCount;
		clearBase = clearCount;
		@(posedge clk);
		case (op)
			8'h01:
			begin
				rotaryEvent <= 1'b1;
				rotaryLeft <= 1'b1;
			end
			8'h02:
				rotaryEvent <= 1'b1;
			8'h03:
				rotaryBtn <= 1'b1;
			8'h04:
				colLeftBtn <= 1'b1;
			8'h05:
				colRightBtn <= 1'b1;
			8'h06:
				menuBtn <= 1'b1;
			default:
				rotaryEvent <= 1'b0;
		endcase
		@(posedge clk);
		rotaryEvent <= 1'b0;
		rotaryLeft <= 1'b0;
		rotaryBtn <= 1'b0;
		colLeftBtn <= 1'b0;
		colRightBtn <= 1'b0;
		menuBtn <= 1'b0;
	endtask

	// Screen update is over after 20 cycles without lcdWrite
	task automatic waitQuiet(output logic settled);
		int cycles;
		settled = 1'b0;
		for (cycles = 0; cycles < 600 && !settled; cycles++)
		begin
			@(negedge clk);
			if (quietCount >= 20)
				settled = 1'b1;
		end
	endtask

	// Kind codes match the comment block of the pattern file
	task automatic runCheck(input logic [7:0] kind, input logic [7:0] argA, input logic [7:0] argB);
		int i;
		case (kind)
			8'h01:
			begin
				// Menu screen, line 2 text starts at RAM address 0
				for (i = 0; i < 16; i++)
				begin
					checkChar($sformatf("shadowLcd[%0d]", i), shadowLcd[i],
						menuText(menuItemT'(argA), lcdAddrT'(i)));
					checkChar($sformatf("shadowLcd[%0d]", i + 16), shadowLcd[i + 16],
						menuText(menuItemT'(argB), lcdAddrT'(i)));
				end
				checkItem("menuSelect", menuSelect, menuItemT'(argB));
			end
			8'h02:
			begin
				// Whole local bank on screen
				for (i = 0; i < 32; i++)
					checkChar($sformatf("shadowLcd[%0d]", i), shadowLcd[i], expRam[i]);
			end
			8'h03:
			begin
				checkPulse("ramClear", clearCount != clearBase, 1'b0);
				for (i = 0; i < 32; i++)
					checkChar($sformatf("localRam[%0d]", i), localRam[i], expRam[i]);
			end
			8'h04:
			begin
				// 1 means cursorRight, 2 means cursorLeft
				checkPulse("enableCursor", enableCursor, 1'b1);
				checkPulse("cursorRight", rightCount != rightBase, argA == 8'h01);
				checkPulse("cursorLeft", leftCount != leftBase, argA == 8'h02);
			end
			8'h05:
			begin
				// Redrawn character and its place
				checkPulse("lcdWrite", lcdWriteCount != lcdWriteBase, 1'b1);
				checkAddr("lcdAddr", lastLcdAddr, lcdAddrT'(argA));
				checkChar($sformatf("shadowLcd[%0d]", argA[4:0]), shadowLcd[argA[4:0]], argB);
			end
			8'h06:
			begin
				checkPulse("ramWrite", ramWriteCount != ramWriteBase, 1'b1);
				checkAddr("ramAddr", lastRamAddr, lcdAddrT'(argA));
				checkChar("ramDin", lastRamDin, argB);
				checkChar($sformatf("localRam[%0d]", argA[4:0]), localRam[argA[4:0]], argB);
				expRam[argA[4:0]] = argB;
			end
			8'h07:
			begin
				checkPulse("ramClear", clearCount != clearBase, 1'b1);
				if (clearCount - clearBase > 1)
				begin
					errorCount++;
					$display("ramClear pulsed %0d times for one confirmation",
						clearCount - clearBase);
				end
				for (i = 0; i < 32; i++)
				begin
					expRam[i] = '0;
					checkChar($sformatf("localRam[%0d]", i), localRam[i], '0);
				end
			end
			default:
				checkCount = checkCount;
		endcase
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int seedVal;
		int i;
		int step;
		logic settled;
		logic timedOut;
		logic [7:0] op;
		timedOut = 1'b0;
		rstN <= 1'b0;
		rotaryEvent <= 1'b0;
		rotaryLeft <= 1'b0;
		rotaryBtn <= 1'b0;
		colLeftBtn <= 1'b0;
		colRightBtn <= 1'b0;
		menuBtn <= 1'b0;

		// Local bank contents from the fixed seed
		seedVal = $urandom(15);
		for (i = 0; i < 32; i++)
		begin
			seedRam[i] = charT'($urandom);
			expRam[i] = seedRam[i];
		end
		for (i = 0; i < 256; i++)
			patMem[i] = 8'hff;
		$readmemh("menuPatterns.txt", patMem);
		if (patMem[0] === 8'hff)
		begin
			errorCount++;
			$display("Pattern file menuPatterns.txt is missing or empty");
		end

		// Three cycles of reset, then strobes must be low
		repeat (3) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		checkPulse("lcdWrite", lcdWrite, 1'b0);
		checkPulse("ramWrite", ramWrite, 1'b0);
		checkPulse("ramClear", ramClear, 1'b0);
		checkPulse("cursorLeft", cursorLeft, 1'b0);
		checkPulse("cursorRight", cursorRight, 1'b0);
		checkPulse("enableCursor", enableCursor, 1'b0);

		// Op 00 only waits and checks
		for (step = 0; step < 64 && patMem[4 * step] !== 8'hff && !timedOut; step++)
		begin
			op = patMem[4 * step];
			if (op != 8'h00)
				applyOp(op);
			waitQuiet(settled);
			if (!settled)
			begin
				errorCount++;
				timedOut = 1'b1;
				$display("Timeout: LCD never went quiet after pattern step %0d", step);
			end
			else
				runCheck(patMem[4 * step + 1], patMem[4 * step + 2], patMem[4 * step + 3]);
		end

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* menuPatterns.txt */
// Columns: op kind argA argB, hex; op 0 none 1 rotL 2 rotR 3 select 4 colL 5 colR 6 menu
// Kind: 1 menu title/option 2 local screen 3 bank kept 4 cursor 5 char pos/code 6 commit 7 cleared
00 01 00 03
01 01 00 04
01 01 00 05
01 01 00 03
02 01 00 05
02 01 00 04
02 01 00 03
03 02 00 00
03 01 00 03
02 01 00 05
03 01 08 09
01 01 08 0a
03 01 00 03
00 03 00 00
01 01 00 04
03 02 00 00
01 04 01 00
01 04 01 00
02 04 02 00
01 04 01 00
03 00 00 00
05 05 02 51
05 05 02 61
05 05 02 71
05 05 02 a1
04 05 02 71
01 05 02 72
03 06 02 72
06 01 00 03
01 01 00 04
03 02 00 00
03 00 00 00
04 05 00 31
04 05 00 21
04 05 00 f1
05 05 00 21
06 01 00 03
02 01 00 05
03 01 08 09
03 07 00 00
00 01 00 03
03 02 00 00
06 01 00 03

/* src.f */
menuPkg.sv
lcdBusIf.sv
lcdWriter.sv
charPicker.sv
menuSequencer.sv
lcdMenuTop.sv
tbLcdMenu.sv
